/* Makefile */
# Verilator build and run of the leading-bit count unit

TOP = lzcUnit_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

obj_dir/V$(TOP): src.f hw/*.sv hw/*.svh dv/*.sv
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o V$(TOP)

# the log decides, a missing pass line counts as failure too
sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "ERRORS FOUND" sim.log || ! grep -q "NO ERRORS" sim.log; then \
		echo "simulation failed"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf obj_dir sim.log

/* dv/lzcUnit_assertions.sv */
// --------------------
// assertions bound into the unit top
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "lzc_config.svh"

module lzcUnit_assertions
	import lzc_pkg::*;
(
	input wire logic       clk,
	input wire logic       arstN,
	input wire logic       ce,
	input wire logic       outStb,
	input wire lzcResult_t result
);

	// ce-high edges since reset, saturating at 3
	logic [1:0] ceEdges;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ceEdges <= '0;
		end else if (ce && ceEdges != 2'd3) begin
			ceEdges <= ceEdges + 2'd1;
		end
	end

	outStbQuietAfterReset: assert property (@(posedge clk) disable iff (!arstN)
		(ceEdges != 2'd3) |-> !outStb)
		else $error("outStb rose before three ce edges after reset");

	countInRange: assert property (@(posedge clk) disable iff (!arstN)
		result.count <= `LZC_WIDTH)
		else $error("result count above operand width");

	// a normalized nonzero value has its top bit set
	normTopBitSet: assert property (@(posedge clk) disable iff (!arstN)
		(outStb && result.op == opNorm && result.count != '0 && result.count < `LZC_WIDTH)
		|-> result.value[`LZC_WIDTH-1])
		else $error("normalized value has its top bit clear");

endmodule

bind lzcUnit lzcUnit_assertions lzcUnitAssertions_i (
	.clk    (clk),
	.arstN  (arstN),
	.ce     (ce),
	.outStb (outStb),
	.result (result)
);

`default_nettype wire

/* dv/lzcUnit_tb.sv */
// --------------------
// testbench of the leading-bit count unit
// with reference model and result checker
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "lzc_config.svh"

module lzcUnit_tb
	import lzc_pkg::*;
();

	localparam int width      = `LZC_WIDTH;
	localparam int numRand    = 40;
	localparam int numStress  = 200;
	localparam int latency    = 3;
	// requests over all tests, sets the run limit
	localparam int totalReqs  = 1 + 66 + (5 + numRand) + (2 + numRand) + 64 + numStress;
	localparam int cycleLimit = 4 * totalReqs + 300;

	logic       clk;
	logic       arstN;
	logic       ce;
	logic       inStb;
	lzcReq_t    req;
	logic       outStb;
	lzcResult_t result;

	logic [31:0] lfsrState;
	string       testName;
	logic        idleCheck;

	// expected results and the ce edge of each accepted request
	lzcResult_t expQ[$];
	int         acceptQ[$];

	// written by the checker only
	int errCount    = 0;
	int checkCnt    = 0;
	int resultCount = 0;
	int ceEdges     = 0;

	// written by the stimulus only
	int mainErrs  = 0;
	int testCount = 0;
	int errStart;
	int resStart;
	int mainStart;

	int cycleCnt = 0;

	lzcUnit lzcUnit_i (
		.clk    (clk),
		.arstN  (arstN),
		.ce     (ce),
		.inStb  (inStb),
		.req    (req),
		.outStb (outStb),
		.result (result)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			bits = {bits[30:0], lfsrState[0]};
		end
		return bits;
	endfunction

	// bytes are zero, all ones or random, so long runs are common
	function automatic logic [width-1:0] randOperand();
		logic [width-1:0] v;
		logic [31:0]      rnd;
		for (int b = 0; b < `LZC_BYTES; b++) begin
			rnd = randBits(2);
			case (rnd[1:0])
				2'd0:    v[8*b +: 8] = 8'h00;
				2'd1:    v[8*b +: 8] = 8'hff;
				default: begin
					rnd = randBits(8);
					v[8*b +: 8] = rnd[7:0];
				end
			endcase
		end
		return v;
	endfunction

	function automatic lzcOp_e randOp();
		logic [31:0] rnd;
		rnd = randBits(2);
		case (rnd[1:0])
			2'd0:    return opClz;
			2'd1:    return opClo;
			default: return opNorm;
		endcase
	endfunction

	// bit scan from the top, then the result rules per op
	function automatic lzcResult_t refLzc(input lzcReq_t r);
		lzcResult_t res;
		int         n;
		logic       runBit;
		runBit = (r.op == opClo);
		n = 0;
		while (n < width && r.operand[width-1-n] == runBit) begin
			n++;
		end
		res.op    = r.op;
		res.count = cntWidth'(n);
		if (r.op == opNorm) begin
			res.value = (n == width) ? '0 : (r.operand << n);
		end else begin
			res.value = r.operand;
		end
		return res;
	endfunction

	task automatic checkOp(input lzcOp_e expV, input lzcOp_e actV);
		checkCnt++;
		if (actV !== expV) begin
			$display("ERROR %s op: expected %s, actual %s", testName, expV.name(), actV.name());
			errCount++;
		end
	endtask

	task automatic checkCount(input logic [cntWidth-1:0] expV, input logic [cntWidth-1:0] actV);
		checkCnt++;
		if (actV !== expV) begin
			$display("ERROR %s count: expected %0d, actual %0d", testName, expV, actV);
			errCount++;
		end
	endtask

	task automatic checkValue(input logic [width-1:0] expV, input logic [width-1:0] actV);
		checkCnt++;
		if (actV !== expV) begin
			$display("ERROR %s value: expected %h, actual %h", testName, expV, actV);
			errCount++;
		end
	endtask

	task automatic checkLatency(input int actV);
		checkCnt++;
		if (actV != latency) begin
			$display("ERROR %s latency: expected %0d, actual %0d", testName, latency, actV);
			errCount++;
		end
	endtask

	// checker, sees pre-edge values since inputs move 1 ns later
	always @(posedge clk) begin
		lzcResult_t expRes;
		int         acceptEdge;
		if (arstN && idleCheck) begin
			if (outStb) begin
				$display("%s: outStb is high while the pipeline is empty", testName);
				errCount++;
			end
			checkOp(opClz, result.op);
			checkCount('0, result.count);
			checkValue('0, result.value);
		end
		if (arstN && ce) begin
			if (outStb) begin
				if (expQ.size() == 0) begin
					$display("%s: a result came out with no request waiting", testName);
					errCount++;
				end else begin
					expRes = expQ.pop_front();
					acceptEdge = acceptQ.pop_front();
					checkOp(expRes.op, result.op);
					checkCount(expRes.count, result.count);
					checkValue(expRes.value, result.value);
					checkLatency(ceEdges - acceptEdge);
					resultCount++;
				end
			end
			if (inStb) begin
				expQ.push_back(refLzc(req));
				acceptQ.push_back(ceEdges);
			end
			ceEdges++;
		end
	end

	task automatic driveCycle(input logic ceV, input logic stbV, input lzcOp_e op,
			input logic [width-1:0] operand);
		@(posedge clk);
		#1;
		ce          = ceV;
		inStb       = stbV;
		req.op      = op;
		req.operand = operand;
	endtask

	task automatic sendReq(input lzcOp_e op, input logic [width-1:0] operand);
		driveCycle(1'b1, 1'b1, op, operand);
	endtask

	task automatic startTest(input string name);
		testName  = name;
		errStart  = errCount;
		resStart  = resultCount;
		mainStart = mainErrs;
	endtask

	// idle with ce high until every queued result has come out
	task automatic finishTest();
		int waitCnt;
		waitCnt = 0;
		driveCycle(1'b1, 1'b0, opClz, '0);
		while (expQ.size() != 0 && waitCnt < 2 * latency + 2) begin
			driveCycle(1'b1, 1'b0, opClz, '0);
			waitCnt++;
		end
		if (expQ.size() != 0) begin
			$display("%s: %0d results never came out of the pipeline", testName, expQ.size());
			mainErrs++;
		end
		$display("test %s: %0d results, %0d errors", testName, resultCount - resStart,
			(errCount - errStart) + (mainErrs - mainStart));
		testCount++;
	endtask

	initial begin
		int               accepted;
		logic             ceV;
		logic             stbV;
		logic [width-1:0] operand;
		lfsrState = 32'h3460;
		arstN     = 1'b0;
		ce        = 1'b0;
		inStb     = 1'b0;
		req       = '0;
		idleCheck = 1'b0;
		testName  = "reset";
		repeat (16) @(posedge clk);
		#1;
		arstN     = 1'b1;
		idleCheck = 1'b1;

		// output stays cleared until the first request has gone through
		startTest("resetIdle");
		repeat (6) begin
			driveCycle(randBits(2) != 0, 1'b0, opClz, '0);
		end
		idleCheck = 1'b0;
		sendReq(opClz, randOperand());
		finishTest();

		startTest("clzDirected");
		sendReq(opClz, '0);
		sendReq(opClz, '1);
		for (int i = 0; i < width; i++) begin
			operand = '0;
			operand[i] = 1'b1;
			sendReq(opClz, operand);
		end
		finishTest();

		startTest("cloMixed");
		sendReq(opClo, '1);
		sendReq(opClo, '0);
		operand = '1;
		operand[width-1] = 1'b0;
		sendReq(opClo, operand);
		operand = '0;
		operand[width-1 -: 16] = '1;
		sendReq(opClo, operand);
		operand = randOperand();
		operand[width-1] = 1'b0;
		sendReq(opClo, operand);
		repeat (numRand) sendReq(opClo, randOperand());
		finishTest();

		startTest("normalize");
		sendReq(opNorm, '0);
		operand = '0;
		operand[0] = 1'b1;
		sendReq(opNorm, operand);
		repeat (numRand) sendReq(opNorm, randOperand());
		finishTest();

		startTest("backToBack");
		repeat (64) sendReq(randOp(), randOperand());
		finishTest();

		// ce low about one cycle in four, inStb random
		startTest("stallStress");
		accepted = 0;
		while (accepted < numStress) begin
			ceV  = (randBits(2) != 0);
			stbV = (randBits(1) != 0);
			driveCycle(ceV, stbV, randOp(), randOperand());
			if (ceV && stbV) begin
				accepted++;
			end
		end
		finishTest();

		$display("%0d tests, %0d checks, %0d errors", testCount, checkCnt, errCount + mainErrs);
		if (errCount + mainErrs == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// run limit
	initial begin
		while (cycleCnt < cycleLimit) begin
			@(posedge clk);
			cycleCnt++;
		end
		$display("timeout: the run did not finish within %0d cycles", cycleLimit);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/byteCountStage.sv */
// --------------------
// stage 1: per-byte leading count
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "lzc_config.svh"

module byteCountStage
	import lzc_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       arstN,
	input  wire logic       ce,
	input  wire logic       inStb,
	input  wire lzcReq_t    req,
	output lzcStage1_t      stage1
);

	// operand as seen by the byte counters
	logic [`LZC_WIDTH-1:0] countSrc;
	byteCnt_t              rawCnt;

	// stage registers
	logic                  validQ;
	lzcOp_e                opQ;
	logic [`LZC_WIDTH-1:0] operandQ;
	byteCnt_t              byteCntQ;

	// leading ones are counted as leading zeros of the complement
	assign countSrc = (req.op == opClo) ? ~req.operand : req.operand;

	// one lookup per byte, all in parallel
	for (genvar b = 0; b < `LZC_BYTES; b++) begin : gByte
		leadZeroByte byteCnt_i (
			.byteIn (countSrc[8*b +: 8]),
			.count  (rawCnt[b])
		);
	end

	// valid follows inStb on every enabled edge
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			validQ <= 1'b0;
		end else if (ce) begin
			validQ <= inStb;
		end
	end

	// payload only moves when a request is accepted
	always_ff @(posedge clk) begin
		if (ce && inStb) begin
			opQ      <= req.op;
			operandQ <= req.operand;
			byteCntQ <= rawCnt;
		end
	end

	assign stage1 = '{
		valid:   validQ,
		op:      opQ,
		operand: operandQ,
		byteCnt: byteCntQ
	};

endmodule

`default_nettype wire

/* hw/countMergeStage.sv */
// --------------------
// stage 2: merge of the byte counts
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "lzc_config.svh"

module countMergeStage
	import lzc_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       arstN,
	input  wire logic       ce,
	input  wire lzcStage1_t stage1,
	output lzcStage2_t      stage2
);

	logic                  found;
	logic [cntWidth-1:0]   mergedCnt;

	// stage registers
	logic                  validQ;
	lzcOp_e                opQ;
	logic [`LZC_WIDTH-1:0] operandQ;
	logic [cntWidth-1:0]   countQ;

	// walk down from the top byte
	// a byte counting 8 is all zero, so its 8 carries into the sum;
	// the first byte below 8 adds its count and ends the walk
	always_comb begin
		found     = 1'b0;
		mergedCnt = '0;
		for (int i = `LZC_BYTES - 1; i >= 0; i--) begin
			if (!found) begin
				mergedCnt = mergedCnt + cntWidth'(stage1.byteCnt[i]);
				if (!stage1.byteCnt[i][3]) begin
					found = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			validQ <= 1'b0;
		end else if (ce) begin
			validQ <= stage1.valid;
		end
	end

	// hold payload on bubbles
	always_ff @(posedge clk) begin
		if (ce && stage1.valid) begin
			opQ      <= stage1.op;
			operandQ <= stage1.operand;
			countQ   <= mergedCnt;
		end
	end

	assign stage2 = '{
		valid:   validQ,
		op:      opQ,
		operand: operandQ,
		count:   countQ
	};

endmodule

`default_nettype wire

/* hw/leadZeroByte.sv */
// --------------------
// leading-zero count of a single byte
// --------------------

`timescale 1ns/1ps
`default_nettype none

module leadZeroByte (
	input  wire logic [7:0] byteIn,
	output logic      [3:0] count
);

	// position of the first set bit seen from the top
	// an all-zero byte falls through to 8
	always_comb begin
		casez (byteIn)
			8'b1???????: count = 4'd0;
			8'b01??????: count = 4'd1;
			8'b001?????: count = 4'd2;
			8'b0001????: count = 4'd3;
			8'b00001???: count = 4'd4;
			8'b000001??: count = 4'd5;
			8'b0000001?: count = 4'd6;
			8'b00000001: count = 4'd7;
			default:     count = 4'd8;
		endcase
	end

endmodule

`default_nettype wire

/* hw/lzcUnit.sv */
// --------------------
// top of the three-stage leading-bit count unit
// --------------------

`timescale 1ns/1ps
`default_nettype none

module lzcUnit
	import lzc_pkg::*;
(
	input  wire logic    clk,
	input  wire logic    arstN,
	input  wire logic    ce,
	input  wire logic    inStb,
	input  wire lzcReq_t req,
	output logic         outStb,
	output lzcResult_t   result
);

	// registered stage outputs
	lzcStage1_t stage1;
	lzcStage2_t stage2;

	// byte counts, leading ones via complement
	byteCountStage byteCountStage_i (
		.clk    (clk),
		.arstN  (arstN),
		.ce     (ce),
		.inStb  (inStb),
		.req    (req),
		.stage1 (stage1)
	);

	// operand-wide count
	countMergeStage countMergeStage_i (
		.clk    (clk),
		.arstN  (arstN),
		.ce     (ce),
		.stage1 (stage1),
		.stage2 (stage2)
	);

	// normalize and present the result
	normShiftStage normShiftStage_i (
		.clk    (clk),
		.arstN  (arstN),
		.ce     (ce),
		.stage2 (stage2),
		.outStb (outStb),
		.result (result)
	);

endmodule

`default_nettype wire

/* hw/lzc_config.svh */
// --------------------
// operand width settings for the
// leading-bit count unit
// --------------------

`ifndef LZC_CONFIG_SVH
`define LZC_CONFIG_SVH

// operand width in bits, any multiple of 8
`define LZC_WIDTH 64

// whole bytes in one operand
`define LZC_BYTES (`LZC_WIDTH / 8)

`endif

/* hw/lzc_pkg.sv */
// --------------------
// shared types of the leading-bit count pipeline
// --------------------

`default_nettype none

`include "lzc_config.svh"

package lzc_pkg;

	// bits to hold any count from 0 to the full width
	localparam int cntWidth = $clog2(`LZC_WIDTH + 1);

	// operation codes
	typedef enum logic [1:0] {
		opClz  = 2'd0,
		opClo  = 2'd1,
		opNorm = 2'd2
	} lzcOp_e;

	// request word as presented at the unit input
	typedef struct packed {
		lzcOp_e                op;
		logic [`LZC_WIDTH-1:0] operand;
	} lzcReq_t;

	// one 4-bit count per byte, element 0 is the least significant byte
	typedef logic [`LZC_BYTES-1:0][3:0] byteCnt_t;

	// after the per-byte count
	typedef struct packed {
		logic                  valid;
		lzcOp_e                op;
		logic [`LZC_WIDTH-1:0] operand;
		byteCnt_t              byteCnt;
	} lzcStage1_t;

	// after the merge, count covers the whole operand
	typedef struct packed {
		logic                  valid;
		lzcOp_e                op;
		logic [`LZC_WIDTH-1:0] operand;
		logic [cntWidth-1:0]   count;
	} lzcStage2_t;

	// final result, value is the shifted operand for opNorm
	typedef struct packed {
		lzcOp_e                op;
		logic [cntWidth-1:0]   count;
		logic [`LZC_WIDTH-1:0] value;
	} lzcResult_t;

endpackage

`default_nettype wire

/* hw/normShiftStage.sv */
// --------------------
// stage 3: normalize shift and result register
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "lzc_config.svh"

module normShiftStage
	import lzc_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       arstN,
	input  wire logic       ce,
	input  wire lzcStage2_t stage2,
	output logic            outStb,
	output lzcResult_t      result
);

	// barrel shifter, one level per count bit
	logic [cntWidth:0][`LZC_WIDTH-1:0] shiftChain;
	logic [`LZC_WIDTH-1:0]             nextValue;

	assign shiftChain[0] = stage2.operand;

	// level k shifts by 2**k when count bit k is set
	// a full-width count shifts everything out, leaving zero
	for (genvar k = 0; k < cntWidth; k++) begin : gShift
		assign shiftChain[k+1] = stage2.count[k] ? (shiftChain[k] << (2**k))
		                                         : shiftChain[k];
	end

	always_comb begin
		case (stage2.op)
			opNorm:  nextValue = shiftChain[cntWidth];
			default: nextValue = stage2.operand;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outStb <= 1'b0;
		end else if (ce) begin
			outStb <= stage2.valid;
		end
	end

	// result is visible at the output, so it starts from zero
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			result <= '0;
		end else if (ce && stage2.valid) begin
			result.op    <= stage2.op;
			result.count <= stage2.count;
			result.value <= nextValue;
		end
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+hw
hw/lzc_pkg.sv
hw/leadZeroByte.sv
hw/byteCountStage.sv
hw/countMergeStage.sv
hw/normShiftStage.sv
hw/lzcUnit.sv
dv/lzcUnit_assertions.sv
dv/lzcUnit_tb.sv
